/* zx_defs.svh */
// Spectrum paging core shared constants
// Bus widths, ROM placement, port decode patterns and fixed banks

`ifndef ZX_DEFS_SVH
`define ZX_DEFS_SVH

// Bus widths
`define ZX_ADDR_W      16
`define ZX_DATA_W      8
`define ZX_RAM_ADDR_W  25
`define ZX_PAGE_W      14
`define ZX_BANK_W      6

// ROM area, physical bits 20:18 when set to this pattern
`define ZX_ROM_BASE_BANK  3'b101

// High address nibble of the +3 and Pentagon 1024 ports
`define ZX_PORT_1FFD_HI  4'b0001
`define ZX_PORT_EFF7_HI  4'b1110

// Fixed banks behind CPU slots 1 and 2 in normal mode
`define ZX_BANK_SCREEN  6'd5
`define ZX_BANK_MID     6'd2

`endif

/* zx_pkg.sv */
// Spectrum paging core types
// Machine selection and the layouts of the paging port bytes

`default_nettype none

package zx_pkg;

	// Encoding follows the memory menu of the full machine
	typedef enum logic [2:0] {
		MACH_128   = 3'd0,
		MACH_P1024 = 3'd1,
		MACH_48    = 3'd3,
		MACH_PLUS3 = 3'd4
	} machine_t;

	// ==================================================
	// Port 7FFD
	// ==================================================

	// Plain 128K meaning of the byte
	typedef struct packed {
		logic [1:0] rsvd;
		logic       lock;
		logic       rom_sel;
		logic       screen;
		logic [2:0] bank;
	} p7ffd_base_t;

	// Pentagon 1024 reuses the top bits as extra bank bits
	typedef struct packed {
		logic [1:0] ext_hi;
		logic       ext_lo;
		logic [4:0] rsvd;
	} p7ffd_pent_t;

	typedef union packed {
		p7ffd_base_t base;
		p7ffd_pent_t pent;
	} port7ffd_u;

	// ==================================================
	// Port 1FFD (+3)
	// ==================================================

	// Bit 2 is the high ROM select in normal mode and the top bit
	// of the special config in special mode
	typedef struct packed {
		logic [3:0] rsvd;
		logic       motor;
		logic       rom_hi;
		logic       cfg_lo;
		logic       special;
	} port1ffd_t;

endpackage

`default_nettype wire

/* zx_port_decode.sv */
// Decode stage of the paging core
// Turns a rising I/O write into a one-cycle strobe for the port it hits

`timescale 1ns/1ps
`default_nettype none

`include "zx_defs.svh"

module zx_port_decode (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_wr,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic                  is_plus3,
	input  logic                  is_p1024,
	input  logic                  page_disable,
	output logic                  wr_7ffd,
	output logic                  wr_1ffd,
	output logic                  wr_eff7,
	output logic                  wr_fe
);

	logic io_wr_q;
	logic wr_new;
	logic [3:0] addr_hi;

	// Previous level of the write strobe
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// First cycle of a write only
	assign wr_new  = io_wr & ~io_wr_q;
	assign addr_hi = addr[15:12];

	// ==================================================
	// Port matching, partial decode as on the real boards
	// ==================================================

	// 7FFD, the +3 also wants A14 so it does not clash with 1FFD
	assign wr_7ffd = wr_new & ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3)
		& ~page_disable;

	assign wr_1ffd = wr_new & (addr_hi == `ZX_PORT_1FFD_HI) & ~addr[1] & is_plus3
		& ~page_disable;

	// EFF7 stays writable after 7FFD is locked
	assign wr_eff7 = wr_new & (addr_hi == `ZX_PORT_EFF7_HI) & ~addr[3] & is_p1024;

	// ULA port, any even address
	assign wr_fe = wr_new & ~addr[0];

	// The two +3 paging ports must never be written by one cycle
	a_7ffd_1ffd_excl: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(wr_7ffd && wr_1ffd)
	);

endmodule

`default_nettype wire

/* zx_port_regs.sv */
// Execute stage of the paging core
// Paging registers, the ULA output latch and the machine flags

`timescale 1ns/1ps
`default_nettype none

`include "zx_defs.svh"

module zx_port_regs import zx_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  machine_t              machine,
	input  logic                  wr_7ffd,
	input  logic                  wr_1ffd,
	input  logic                  wr_eff7,
	input  logic                  wr_fe,
	input  logic [`ZX_DATA_W-1:0] data,
	output port7ffd_u             reg_7ffd,
	output port1ffd_t             reg_1ffd,
	output logic [2:0]            bank_ext,
	output logic                  is_48,
	output logic                  is_plus3,
	output logic                  is_p1024,
	output logic                  page_disable,
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out
);

	// EFF7 bit 2 drops the Pentagon back to plain 128K paging
	logic eff7_128;

	// Incoming byte seen through both 7FFD layouts
	port7ffd_u data_7ffd;

	assign data_7ffd = data;

	// ==================================================
	// Paging registers
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Machine type is only picked up while reset is held
			is_48    <= (machine == MACH_48);
			is_plus3 <= (machine == MACH_PLUS3);
			is_p1024 <= (machine == MACH_P1024);
			reg_7ffd <= '0;
			reg_1ffd <= '0;
			bank_ext <= '0;
			eff7_128 <= 1'b0;
		end else begin
			if (wr_7ffd) begin
				reg_7ffd <= data_7ffd;
				// Extension order is ext_lo then ext_hi
				if (is_p1024 && !eff7_128) begin
					bank_ext <= {data_7ffd.pent.ext_lo, data_7ffd.pent.ext_hi};
				end
			end
			if (wr_1ffd) begin
				reg_1ffd <= data;
			end
			if (wr_eff7) begin
				eff7_128 <= data[2];
			end
		end
	end

	// Bit 5 only locks on a Pentagon once it runs in 128K mode
	assign page_disable = is_48
		| (reg_7ffd.base.lock & (~is_p1024 | eff7_128));

	// ==================================================
	// ULA port FE
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (wr_fe) begin
			border_color <= data[2:0];
			ear_out      <= data[4];
			mic_out      <= data[3];
		end
	end

	// 48K never pages, so the decode stage must keep both registers frozen
	a_48k_locked: assert property (
		@(posedge clk_sys) disable iff (reset)
		is_48 |-> (page_disable && $stable(reg_7ffd) && $stable(reg_1ffd))
	);

endmodule

`default_nettype wire

/* zx_mem_map.sv */
// Result stage of the paging core
// Maps a CPU address to a physical RAM or ROM address, combinational

`timescale 1ns/1ps
`default_nettype none

`include "zx_defs.svh"

module zx_mem_map import zx_pkg::*; (
	input  logic [`ZX_ADDR_W-1:0]     addr,
	input  port7ffd_u                 reg_7ffd,
	input  port1ffd_t                 reg_1ffd,
	input  logic [2:0]                bank_ext,
	input  logic                      is_48,
	input  logic                      is_plus3,
	output logic [`ZX_RAM_ADDR_W-1:0] ram_addr,
	output logic                      ram_we_ok,
	output logic [3:0]                rom_page,
	output logic                      page_scr
);

	logic [1:0]               slot;
	logic [1:0]               special_cfg;
	logic [11:0]              special_set;
	logic [`ZX_BANK_W-1:0]    bank;
	logic                     in_rom;
	logic [`ZX_PAGE_W-1:0]    offset;

	assign slot        = addr[15:14];
	assign offset      = addr[`ZX_PAGE_W-1:0];
	assign special_cfg = {reg_1ffd.rom_hi, reg_1ffd.cfg_lo};
	assign page_scr    = reg_7ffd.base.screen;

	// ==================================================
	// ROM page select
	// ==================================================

	always_comb begin
		if (is_48) begin
			rom_page = 4'b1111;
		end else if (is_plus3) begin
			rom_page = {2'b10, reg_1ffd.rom_hi, reg_7ffd.base.rom_sel};
		end else begin
			rom_page = {3'b011, reg_7ffd.base.rom_sel};
		end
	end

	// +3 all-RAM bank sets, slot 3 in the top three bits
	always_comb begin
		case (special_cfg)
			2'd0:    special_set = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    special_set = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    special_set = {3'd3, 3'd6, 3'd5, 3'd4};
			default: special_set = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
	end

	// ==================================================
	// Slot to bank
	// ==================================================

	always_comb begin
		in_rom = 1'b0;
		bank   = '0;
		if (reg_1ffd.special) begin
			bank = {3'd0, special_set[slot*3 +: 3]};
		end else begin
			case (slot)
				2'd0:    in_rom = 1'b1;
				2'd1:    bank = `ZX_BANK_SCREEN;
				2'd2:    bank = `ZX_BANK_MID;
				default: bank = {bank_ext, reg_7ffd.base.bank};
			endcase
		end
	end

	// Banks are 16K apart from address zero, ROMs sit above them
	always_comb begin
		if (in_rom) begin
			ram_addr = {{(`ZX_RAM_ADDR_W - `ZX_PAGE_W - 7){1'b0}},
				`ZX_ROM_BASE_BANK, rom_page, offset};
		end else begin
			ram_addr = {{(`ZX_RAM_ADDR_W - `ZX_PAGE_W - `ZX_BANK_W){1'b0}},
				bank, offset};
		end
	end

	// ROM is read only
	assign ram_we_ok = ~in_rom;

	// A write enable must never reach the ROM area
	always_comb begin
		a_no_rom_write: assert (!(ram_we_ok && ram_addr[20:18] == `ZX_ROM_BASE_BANK));
	end

endmodule

`default_nettype wire

/* zx_paging_top.sv */
// Spectrum memory paging core
// Port decode, paging registers and address mapping in three stages

`timescale 1ns/1ps
`default_nettype none

`include "zx_defs.svh"

module zx_paging_top import zx_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  machine_t                  machine,
	input  logic                      io_wr,
	input  logic [`ZX_ADDR_W-1:0]     addr,
	input  logic [`ZX_DATA_W-1:0]     data,
	output logic [`ZX_RAM_ADDR_W-1:0] ram_addr,
	output logic                      ram_we_ok,
	output logic                      page_scr,
	output logic [3:0]                rom_page,
	output logic                      page_disable,
	output logic [2:0]                border_color,
	output logic                      ear_out,
	output logic                      mic_out
);

	// One-cycle port strobes
	logic wr_7ffd;
	logic wr_1ffd;
	logic wr_eff7;
	logic wr_fe;

	// Register state towards the mapper
	port7ffd_u  reg_7ffd;
	port1ffd_t  reg_1ffd;
	logic [2:0] bank_ext;
	logic       is_48;
	logic       is_plus3;
	logic       is_p1024;

	zx_port_decode u_decode (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_wr        (io_wr),
		.addr         (addr),
		.is_plus3     (is_plus3),
		.is_p1024     (is_p1024),
		.page_disable (page_disable),
		.wr_7ffd      (wr_7ffd),
		.wr_1ffd      (wr_1ffd),
		.wr_eff7      (wr_eff7),
		.wr_fe        (wr_fe)
	);

	zx_port_regs u_regs (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.wr_7ffd      (wr_7ffd),
		.wr_1ffd      (wr_1ffd),
		.wr_eff7      (wr_eff7),
		.wr_fe        (wr_fe),
		.data         (data),
		.reg_7ffd     (reg_7ffd),
		.reg_1ffd     (reg_1ffd),
		.bank_ext     (bank_ext),
		.is_48        (is_48),
		.is_plus3     (is_plus3),
		.is_p1024     (is_p1024),
		.page_disable (page_disable),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	zx_mem_map u_map (
		.addr      (addr),
		.reg_7ffd  (reg_7ffd),
		.reg_1ffd  (reg_1ffd),
		.bank_ext  (bank_ext),
		.is_48     (is_48),
		.is_plus3  (is_plus3),
		.ram_addr  (ram_addr),
		.ram_we_ok (ram_we_ok),
		.rom_page  (rom_page),
		.page_scr  (page_scr)
	);

endmodule

`default_nettype wire

/* tb_zx_paging.sv */
// Testbench for the Spectrum paging core
// Directed tests for port decode, paging registers and address mapping

`timescale 1ns/1ps
`default_nettype none

`include "zx_defs.svh"

module tb_zx_paging import zx_pkg::*; ();

	localparam int CLK_PERIOD      = 4;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 200;

	// ROM area base, pattern 101 on physical bits 20:18
	localparam logic [`ZX_RAM_ADDR_W-1:0] ROM_AREA = {4'b0, `ZX_ROM_BASE_BANK, 18'b0};

	logic                      clk_sys;
	logic                      reset;
	machine_t                  machine;
	logic                      io_wr;
	logic [`ZX_ADDR_W-1:0]     addr;
	logic [`ZX_DATA_W-1:0]     data;
	logic [`ZX_RAM_ADDR_W-1:0] ram_addr;
	logic                      ram_we_ok;
	logic                      page_scr;
	logic [3:0]                rom_page;
	logic                      page_disable;
	logic [2:0]                border_color;
	logic                      ear_out;
	logic                      mic_out;

	integer seed = 32'h3809d9ea;
	int     errors;
	int     checks;
	int     tests_run;
	int     errors_at_start;
	string  cur_test;

	zx_paging_top u_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.machine      (machine),
		.io_wr        (io_wr),
		.addr         (addr),
		.data         (data),
		.ram_addr     (ram_addr),
		.ram_we_ok    (ram_we_ok),
		.page_scr     (page_scr),
		.rom_page     (rom_page),
		.page_disable (page_disable),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Timeout: the tests did not complete within %0d ns",
			NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("ERRORS FOUND");
		$finish;
	end

	// ==================================================
	// Reference model
	// ==================================================

	// RAM bank b starts at b times 16K
	function automatic logic [`ZX_RAM_ADDR_W-1:0] bank_addr(input logic [5:0] b,
		input logic [`ZX_PAGE_W-1:0] off);
		logic [`ZX_RAM_ADDR_W-1:0] base;
		base = {{(`ZX_RAM_ADDR_W - 6){1'b0}}, b};
		return (base << `ZX_PAGE_W) + {{(`ZX_RAM_ADDR_W - `ZX_PAGE_W){1'b0}}, off};
	endfunction

	function automatic logic [`ZX_RAM_ADDR_W-1:0] rom_addr(input logic [3:0] page,
		input logic [`ZX_PAGE_W-1:0] off);
		logic [`ZX_RAM_ADDR_W-1:0] base;
		base = {{(`ZX_RAM_ADDR_W - 4){1'b0}}, page};
		return ROM_AREA + (base << `ZX_PAGE_W)
			+ {{(`ZX_RAM_ADDR_W - `ZX_PAGE_W){1'b0}}, off};
	endfunction

	// +3 all-RAM configurations
	function automatic logic [5:0] special_bank(input logic [1:0] cfg, input logic [1:0] slot);
		logic [5:0] b;
		case (cfg)
			2'd0:    b = {4'd0, slot};
			2'd1:    b = {4'd1, slot};
			2'd2:    b = (slot == 2'd3) ? 6'd3 : {4'd1, slot};
			default: b = (slot == 2'd1) ? 6'd7 : ((slot == 2'd3) ? 6'd3 : {4'd1, slot});
		endcase
		return b;
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_addr(input logic [`ZX_RAM_ADDR_W-1:0] exp,
		input logic [`ZX_RAM_ADDR_W-1:0] act, input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %07h, actual %07h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_page(input logic [3:0] exp, input logic [3:0] act, input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %04b, actual %04b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_color(input logic [2:0] exp, input logic [2:0] act, input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input logic exp, input logic act, input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	// ==================================================
	// Bus driving
	// ==================================================

	task automatic reset_dut(input machine_t m);
		@(negedge clk_sys);
		machine = m;
		reset   = 1'b1;
		io_wr   = 1'b0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// Write level held for two cycles, then released
	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		addr  = a;
		data  = d;
		io_wr = 1'b1;
		repeat (2) @(negedge clk_sys);
		io_wr = 1'b0;
	endtask

	task automatic probe(input logic [15:0] a);
		@(negedge clk_sys);
		addr = a;
		#1;
	endtask

	task automatic expect_bank(input logic [15:0] a, input logic [5:0] b);
		probe(a);
		check_addr(bank_addr(b, a[`ZX_PAGE_W-1:0]), ram_addr, $sformatf("ram_addr @%04h", a));
	endtask

	task automatic start_test(input string name);
		cur_test        = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%-16s passed", cur_test);
		end else begin
			$display("%-16s failed with %0d mismatches", cur_test, errors - errors_at_start);
		end
	endtask

	// ==================================================
	// Tests
	// ==================================================

	task automatic reset_defaults_128();
		start_test("reset_128");
		reset_dut(MACH_128);
		expect_bank(16'hC123, 6'd0);
		check_page(4'b0110, rom_page, "rom_page");
		probe(16'h0000);
		check_bit(1'b0, ram_we_ok, "ram_we_ok");
		check_addr(rom_addr(4'b0110, 14'h0000), ram_addr, "rom address");
		check_color(3'd0, border_color, "border_color");
		check_bit(1'b0, ear_out, "ear_out");
		check_bit(1'b0, mic_out, "mic_out");
		finish_test();
	endtask

	task automatic paging_128();
		logic [31:0] r;
		logic [7:0]  d;
		start_test("paging_128");
		reset_dut(MACH_128);
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			d = {r[7:6], 1'b0, r[4:0]};
			io_write(16'h7FFD, d);
			expect_bank({2'b11, r[21:8]}, {3'd0, d[2:0]});
			check_bit(d[3], page_scr, "page_scr");
			check_page({3'b011, d[4]}, rom_page, "rom_page");
		end
		// Lock with bank 3, then try to move away
		io_write(16'h7FFD, 8'h23);
		expect_bank(16'hC000, 6'd3);
		check_bit(1'b1, page_disable, "page_disable");
		io_write(16'h7FFD, 8'h0E);
		expect_bank(16'hC000, 6'd3);
		check_bit(1'b0, page_scr, "page_scr after lock");
		finish_test();
	endtask

	task automatic special_plus3();
		logic [1:0] cfg;
		start_test("special_plus3");
		reset_dut(MACH_PLUS3);
		for (int c = 0; c < 4; c++) begin
			cfg = c[1:0];
			io_write(16'h1FFD, {5'b0, cfg, 1'b1});
			for (int s = 0; s < 4; s++) begin
				expect_bank({s[1:0], 14'h0ABC}, special_bank(cfg, s[1:0]));
			end
			probe(16'h0000);
			check_bit(1'b1, ram_we_ok, "ram_we_ok slot 0");
		end
		// Back to normal mode with both ROM select bits set
		io_write(16'h1FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		probe(16'h0000);
		check_page(4'b1011, rom_page, "rom_page");
		check_bit(1'b0, ram_we_ok, "ram_we_ok in ROM");
		finish_test();
	endtask

	task automatic extended_p1024();
		start_test("extended_p1024");
		reset_dut(MACH_P1024);
		// Extension bits ordered as bit 5 then bits 7:6
		io_write(16'h7FFD, 8'b1100_0010);
		expect_bank(16'hC000, {1'b0, 2'b11, 3'd2});
		io_write(16'h7FFD, 8'b0110_0111);
		expect_bank(16'hC000, {1'b1, 2'b01, 3'd7});
		check_bit(1'b0, page_disable, "page_disable before EFF7");
		io_write(16'h7FFD, 8'h01);
		io_write(16'hEFF7, 8'h04);
		io_write(16'h7FFD, 8'hC4);
		expect_bank(16'hC000, 6'd4);
		check_bit(1'b0, page_disable, "page_disable after EFF7");
		io_write(16'h7FFD, 8'h22);
		expect_bank(16'hC000, 6'd2);
		check_bit(1'b1, page_disable, "page_disable locked");
		io_write(16'h7FFD, 8'h05);
		expect_bank(16'hC000, 6'd2);
		finish_test();
	endtask

	task automatic fixed_48k();
		start_test("fixed_48k");
		reset_dut(MACH_48);
		probe(16'h0000);
		check_bit(1'b1, page_disable, "page_disable");
		check_page(4'b1111, rom_page, "rom_page");
		check_addr(rom_addr(4'b1111, 14'h0000), ram_addr, "rom address");
		io_write(16'h7FFD, 8'h1F);
		expect_bank(16'hC000, 6'd0);
		check_bit(1'b0, page_scr, "page_scr");
		check_page(4'b1111, rom_page, "rom_page after write");
		finish_test();
	endtask

	task automatic ula_port_fe();
		logic [31:0] r;
		start_test("ula_port_fe");
		reset_dut(MACH_128);
		for (int i = 0; i < 3; i++) begin
			r = $random(seed);
			io_write(16'h00FE, r[7:0]);
			probe(16'h0000);
			check_color(r[2:0], border_color, "border_color");
			check_bit(r[4], ear_out, "ear_out");
			check_bit(r[3], mic_out, "mic_out");
		end
		// Even address that also hits 7FFD
		io_write(16'h7FFC, 8'h0B);
		expect_bank(16'hC000, 6'd3);
		check_color(3'd3, border_color, "border_color shared");
		check_bit(1'b1, page_scr, "page_scr shared");
		finish_test();
	endtask

	initial begin
		reset   = 1'b1;
		machine = MACH_128;
		io_wr   = 1'b0;
		addr    = '0;
		data    = '0;
		errors  = 0;
		checks  = 0;
		tests_run = 0;

		reset_defaults_128();
		paging_128();
		special_plus3();
		extended_p1024();
		fixed_48k();
		ula_port_fe();

		$display("Tests: %0d, checks: %0d, mismatches: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
zx_pkg.sv
zx_port_decode.sv
zx_port_regs.sv
zx_mem_map.sv
zx_paging_top.sv
tb_zx_paging.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the paging core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_zx_paging -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
